// ==== periph_bus_config.svh ====
// Build-time constants for the peripheral bus wrapper.
// Included by the package and by every module that decodes addresses or offsets.
`ifndef PERIPH_BUS_CONFIG_SVH
`define PERIPH_BUS_CONFIG_SVH

// slot counts
`define PB_USER_SLOTS    8
`define PB_SIMPLE_SLOTS  4
`define PB_EXT_FIRST     2
`define PB_PINS          8

// address fields, bit 9 selects the simple region
`define PB_ADDR_W          10
`define PB_SIMPLE_BIT      9
`define PB_USER_IDX_MSB    8
`define PB_USER_IDX_LSB    6
`define PB_SIMPLE_IDX_MSB  5
`define PB_SIMPLE_IDX_LSB  4
`define PB_OFS_MSB         5

// fixed slot placement and reset routing
`define PB_GPIO_SLOT  1
`define PB_UART_SLOT  2

// gpio register offsets
`define PB_GPIO_OUT_OFS    6'h00
`define PB_GPIO_IN_OFS     6'h04
`define PB_GPIO_AUDIO_OFS  6'h10
`define PB_GPIO_FSEL_BASE  6'h20
// bits 4..2 carry the pin number
`define PB_GPIO_FSEL_MASK  6'h23

// audio taps as {function select, bit number}
`define PB_AUDIO_TAP0_SEL  {4'h7, 3'd7}
`define PB_AUDIO_TAP1_SEL  {4'h5, 3'd7}
`define PB_AUDIO_TAP2_SEL  {4'h8, 3'd0}
`define PB_AUDIO_TAP3_SEL  {4'h9, 3'd7}
`define PB_AUDIO_TAP4_SEL  {4'h4, 3'd7}
`define PB_AUDIO_TAP5_SEL  {4'hA, 3'd7}
`define PB_AUDIO_TAP6_SEL  {4'h7, 3'd6}
`define PB_AUDIO_TAP7_SEL  {4'h3, 3'd7}

`endif

// ==== periph_bus_pkg.sv ====
// Shared types for the peripheral bus wrapper.
// Compile before any module that names these types.
`default_nettype none

`include "periph_bus_config.svh"

package periph_bus_pkg;

    // bus data toward the core and the user slots
    typedef logic [31:0] word_t;
    // simple slot data and pin vectors
    typedef logic [7:0] byte_t;
    typedef logic [`PB_ADDR_W-1:0] addr_t;
    // offset inside one user slot
    typedef logic [`PB_OFS_MSB:0] offset_t;

    typedef logic [2:0] user_idx_t;
    typedef logic [1:0] simple_idx_t;

    // bit 3 picks a simple slot, low bits are the slot index
    typedef logic [3:0] fsel_t;
    // bit 3 enables audio, bits 2..0 pick a tap
    typedef logic [3:0] audio_sel_t;

    // access size on the read and write strobes, all ones when idle
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10,
        NONE = 2'b11
    } access_n_t;

endpackage

`default_nettype wire

// ==== periph_slot_select.sv ====
// Address decode for the peripheral window.
// Gates the core strobes to the selected slot and muxes its read data and ready.
`default_nettype none

`include "periph_bus_config.svh"

module periph_slot_select (
    input  wire periph_bus_pkg::addr_t                          i_addr,
    input  wire periph_bus_pkg::access_n_t                      i_write_n,
    input  wire periph_bus_pkg::access_n_t                      i_read_n_masked,
    input  wire periph_bus_pkg::word_t [`PB_USER_SLOTS-1:0]     i_user_rdata_all,
    input  wire [`PB_USER_SLOTS-1:0]                            i_user_ready_all,
    input  wire periph_bus_pkg::byte_t [`PB_SIMPLE_SLOTS-1:0]   i_simple_rdata,
    output logic                                                o_gpio_sel,
    output periph_bus_pkg::access_n_t [`PB_USER_SLOTS-1:0]      o_user_write_n,
    output periph_bus_pkg::access_n_t [`PB_USER_SLOTS-1:0]      o_user_read_n,
    output logic [`PB_SIMPLE_SLOTS-1:0]                         o_simple_write,
    output periph_bus_pkg::word_t                               o_sel_rdata,
    output logic                                                o_sel_ready
);
    import periph_bus_pkg::*;

    logic                         simple_region;
    user_idx_t                    user_idx;
    simple_idx_t                  simple_idx;
    logic [`PB_USER_SLOTS-1:0]    user_sel;
    logic [`PB_SIMPLE_SLOTS-1:0]  simple_sel;

    assign simple_region = i_addr[`PB_SIMPLE_BIT];
    assign user_idx      = i_addr[`PB_USER_IDX_MSB:`PB_USER_IDX_LSB];
    assign simple_idx    = i_addr[`PB_SIMPLE_IDX_MSB:`PB_SIMPLE_IDX_LSB];

    // one-hot slot select
    always_comb begin
        user_sel   = '0;
        simple_sel = '0;
        if (simple_region) begin
            simple_sel[simple_idx] = 1'b1;
        end else begin
            user_sel[user_idx] = 1'b1;
        end
    end

    assign o_gpio_sel = user_sel[`PB_GPIO_SLOT];

    genvar k;
    generate
        for (k = 0; k < `PB_USER_SLOTS; k++) begin : g_user
            // unselected slots see an idle bus
            assign o_user_write_n[k] = user_sel[k] ? i_write_n : NONE;
            assign o_user_read_n[k]  = user_sel[k] ? i_read_n_masked : NONE;
        end
        for (k = 0; k < `PB_SIMPLE_SLOTS; k++) begin : g_simple
            assign o_simple_write[k] = simple_sel[k] && (i_write_n != NONE);
        end
    endgenerate

    // simple slots answer in the same cycle
    always_comb begin
        if (simple_region) begin
            o_sel_rdata = {24'h0, i_simple_rdata[simple_idx]};
            o_sel_ready = 1'b1;
        end else begin
            o_sel_rdata = i_user_rdata_all[user_idx];
            o_sel_ready = i_user_ready_all[user_idx];
        end
    end

endmodule

`default_nettype wire

// ==== periph_read_hold.sv ====
// Registered read return toward the core.
// Captures the slot's data once per read and holds it until the core's read complete.
`default_nettype none

module periph_read_hold (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire periph_bus_pkg::access_n_t   i_read_n,
    input  wire                              i_read_complete,
    input  wire periph_bus_pkg::access_n_t   i_write_n,
    input  wire periph_bus_pkg::word_t       i_sel_rdata,
    input  wire                              i_sel_ready,
    output periph_bus_pkg::access_n_t        o_read_n_masked,
    output periph_bus_pkg::word_t            o_rdata,
    output logic                             o_data_ready
);
    import periph_bus_pkg::*;

    logic   hold;
    logic   ready_r;
    logic   capture;
    word_t  rdata_r;

    assign capture = !hold && (i_read_n != NONE) && i_sel_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            ready_r <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_r <= i_sel_rdata;
        end
    end

    // slot must not see a second read while the result is on its way out
    assign o_read_n_masked = ready_r ? NONE : i_read_n;

    assign o_rdata = rdata_r;
    // writes complete in the cycle they are issued
    assign o_data_ready = ready_r || (i_write_n != NONE);

endmodule

`default_nettype wire

// ==== periph_gpio_regs.sv ====
// GPIO block that sits in user slot 1.
// Holds the output register, the per-pin function selects and the audio select.
`default_nettype none

`include "periph_bus_config.svh"

module periph_gpio_regs (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        i_sel,
    input  wire periph_bus_pkg::access_n_t             i_write_n,
    input  wire periph_bus_pkg::offset_t               i_offset,
    input  wire periph_bus_pkg::word_t                 i_wdata,
    input  wire periph_bus_pkg::byte_t                 i_ui_in,
    output periph_bus_pkg::word_t                      o_rdata,
    output periph_bus_pkg::byte_t                      o_gpio_out,
    output periph_bus_pkg::fsel_t [`PB_PINS-1:0]       o_fsel,
    output periph_bus_pkg::audio_sel_t                 o_audio_sel
);
    import periph_bus_pkg::*;

    logic  wr_en;
    logic  fsel_hit;
    byte_t gpio_out;
    fsel_t [`PB_PINS-1:0] fsel;
    audio_sel_t audio_sel;

    assign wr_en    = i_sel && (i_write_n != NONE);
    assign fsel_hit = (i_offset & `PB_GPIO_FSEL_MASK) == `PB_GPIO_FSEL_BASE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_sel <= '0;
        end else if (wr_en) begin
            if (i_offset == `PB_GPIO_OUT_OFS) begin
                gpio_out <= i_wdata[7:0];
            end
            if (i_offset == `PB_GPIO_AUDIO_OFS) begin
                audio_sel <= i_wdata[3:0];
            end
        end
    end

    genvar n;
    generate
        for (n = 0; n < `PB_PINS; n++) begin : g_fsel
            // pins 0 and 1 come up on the UART
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    fsel[n] <= (n < 2) ? fsel_t'(`PB_UART_SLOT) : fsel_t'(`PB_GPIO_SLOT);
                end else if (wr_en && fsel_hit && i_offset[4:2] == n) begin
                    fsel[n] <= i_wdata[3:0];
                end
            end
        end
    endgenerate

    always_comb begin
        o_rdata = '0;
        if (i_offset == `PB_GPIO_OUT_OFS) begin
            o_rdata = {24'h0, gpio_out};
        end else if (i_offset == `PB_GPIO_IN_OFS) begin
            o_rdata = {24'h0, i_ui_in};
        end else if (i_offset == `PB_GPIO_AUDIO_OFS) begin
            o_rdata = {28'h0, audio_sel};
        end else if (fsel_hit) begin
            o_rdata = {28'h0, fsel[i_offset[4:2]]};
        end
    end

    assign o_gpio_out  = gpio_out;
    assign o_fsel      = fsel;
    assign o_audio_sel = audio_sel;

endmodule

`default_nettype wire

// ==== periph_pin_mux.sv ====
// Output pin routing and the audio tap.
// Each pin follows its function select; the audio bit is registered once.
`default_nettype none

`include "periph_bus_config.svh"

module periph_pin_mux (
    input  wire                                                clk,
    input  wire periph_bus_pkg::fsel_t [`PB_PINS-1:0]          i_fsel,
    input  wire periph_bus_pkg::audio_sel_t                    i_audio_sel,
    input  wire periph_bus_pkg::byte_t [`PB_USER_SLOTS-1:0]    i_user_pins_all,
    input  wire periph_bus_pkg::byte_t [`PB_SIMPLE_SLOTS-1:0]  i_simple_pins,
    output periph_bus_pkg::byte_t                              o_uo_out,
    output logic                                               o_audio,
    output logic                                               o_audio_select
);
    import periph_bus_pkg::*;

    localparam logic [6:0] AUDIO_TAPS [8] = '{
        `PB_AUDIO_TAP0_SEL, `PB_AUDIO_TAP1_SEL, `PB_AUDIO_TAP2_SEL, `PB_AUDIO_TAP3_SEL,
        `PB_AUDIO_TAP4_SEL, `PB_AUDIO_TAP5_SEL, `PB_AUDIO_TAP6_SEL, `PB_AUDIO_TAP7_SEL
    };

    logic [6:0] tap;
    byte_t      tap_pins;
    // pin vector of the slot chosen for each output pin
    byte_t [`PB_PINS-1:0] pin_src;

    // pin vector of the slot named by a function select code
    function automatic byte_t slot_pins(input fsel_t code);
        if (code[3]) begin
            return i_simple_pins[code[1:0]];
        end
        return i_user_pins_all[code[2:0]];
    endfunction

    genvar n;
    generate
        for (n = 0; n < `PB_PINS; n++) begin : g_pin
            assign pin_src[n]  = slot_pins(i_fsel[n]);
            assign o_uo_out[n] = pin_src[n][n];
        end
    endgenerate

    // upper four bits of a tap entry are the select, lower three the bit
    assign tap      = AUDIO_TAPS[i_audio_sel[2:0]];
    assign tap_pins = slot_pins(tap[6:3]);

    always_ff @(posedge clk) begin
        o_audio <= tap_pins[tap[2:0]];
    end

    assign o_audio_select = i_audio_sel[3];

endmodule

`default_nettype wire

// ==== periph_bus_top.sv ====
// Peripheral bus wrapper between the core and its slots.
// Slot 0 is reserved, slot 1 is the internal GPIO block, the rest are external ports.
`default_nettype none

`include "periph_bus_config.svh"

module periph_bus_top (
    input  wire                                                                  clk,
    input  wire                                                                  rst_n,
    // core side
    input  wire periph_bus_pkg::addr_t                                           i_addr,
    input  wire periph_bus_pkg::word_t                                           i_wdata,
    input  wire periph_bus_pkg::access_n_t                                       i_write_n,
    input  wire periph_bus_pkg::access_n_t                                       i_read_n,
    input  wire                                                                  i_read_complete,
    output periph_bus_pkg::word_t                                                o_rdata,
    output logic                                                                 o_data_ready,
    input  wire periph_bus_pkg::byte_t                                           i_ui_in,
    output periph_bus_pkg::byte_t                                                o_uo_out,
    output logic                                                                 o_audio,
    output logic                                                                 o_audio_select,
    // external slot side
    output periph_bus_pkg::offset_t                                              o_slot_offset,
    output periph_bus_pkg::word_t                                                o_slot_wdata,
    output periph_bus_pkg::access_n_t [`PB_USER_SLOTS-1:0]                       o_user_write_n,
    output periph_bus_pkg::access_n_t [`PB_USER_SLOTS-1:0]                       o_user_read_n,
    input  wire periph_bus_pkg::word_t [`PB_USER_SLOTS-1:`PB_EXT_FIRST]          i_user_rdata,
    input  wire [`PB_USER_SLOTS-1:`PB_EXT_FIRST]                                 i_user_ready,
    input  wire periph_bus_pkg::byte_t [`PB_USER_SLOTS-1:`PB_EXT_FIRST]          i_user_pins,
    output logic [`PB_SIMPLE_SLOTS-1:0]                                          o_simple_write,
    input  wire periph_bus_pkg::byte_t [`PB_SIMPLE_SLOTS-1:0]                    i_simple_rdata,
    input  wire periph_bus_pkg::byte_t [`PB_SIMPLE_SLOTS-1:0]                    i_simple_pins
);
    import periph_bus_pkg::*;

    word_t [`PB_USER_SLOTS-1:0]  user_rdata_all;
    logic  [`PB_USER_SLOTS-1:0]  user_ready_all;
    byte_t [`PB_USER_SLOTS-1:0]  user_pins_all;

    logic       gpio_sel;
    word_t      gpio_rdata;
    byte_t      gpio_out;
    fsel_t [`PB_PINS-1:0] fsel;
    audio_sel_t audio_sel;

    access_n_t  read_n_masked;
    word_t      sel_rdata;
    logic       sel_ready;

    // slot 0 reads zero and never answers, GPIO is always ready
    assign user_rdata_all = {i_user_rdata, gpio_rdata, 32'h0};
    assign user_ready_all = {i_user_ready, 1'b1, 1'b0};
    assign user_pins_all  = {i_user_pins, gpio_out, 8'h0};

    assign o_slot_offset = i_addr[`PB_OFS_MSB:0];
    assign o_slot_wdata  = i_wdata;

    periph_slot_select i_slot_select (
        .i_addr           (i_addr),
        .i_write_n        (i_write_n),
        .i_read_n_masked  (read_n_masked),
        .i_user_rdata_all (user_rdata_all),
        .i_user_ready_all (user_ready_all),
        .i_simple_rdata   (i_simple_rdata),
        .o_gpio_sel       (gpio_sel),
        .o_user_write_n   (o_user_write_n),
        .o_user_read_n    (o_user_read_n),
        .o_simple_write   (o_simple_write),
        .o_sel_rdata      (sel_rdata),
        .o_sel_ready      (sel_ready)
    );

    periph_read_hold i_read_hold (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_read_complete (i_read_complete),
        .i_write_n       (i_write_n),
        .i_sel_rdata     (sel_rdata),
        .i_sel_ready     (sel_ready),
        .o_read_n_masked (read_n_masked),
        .o_rdata         (o_rdata),
        .o_data_ready    (o_data_ready)
    );

    periph_gpio_regs i_gpio_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_sel       (gpio_sel),
        .i_write_n   (i_write_n),
        .i_offset    (i_addr[`PB_OFS_MSB:0]),
        .i_wdata     (i_wdata),
        .i_ui_in     (i_ui_in),
        .o_rdata     (gpio_rdata),
        .o_gpio_out  (gpio_out),
        .o_fsel      (fsel),
        .o_audio_sel (audio_sel)
    );

    periph_pin_mux i_pin_mux (
        .clk             (clk),
        .i_fsel          (fsel),
        .i_audio_sel     (audio_sel),
        .i_user_pins_all (user_pins_all),
        .i_simple_pins   (i_simple_pins),
        .o_uo_out        (o_uo_out),
        .o_audio         (o_audio),
        .o_audio_select  (o_audio_select)
    );

endmodule

`default_nettype wire

// ==== tb_periph_bus.sv ====
// Testbench for the peripheral bus wrapper.
// Runs the operations in periph_bus_stimulus.txt against models of the external slots.
`default_nettype none

`include "periph_bus_config.svh"

module tb_periph_bus;
    timeunit 1ns;
    timeprecision 100ps;

    import periph_bus_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_LINES  = 64;
    localparam int FIELDS     = 5;

    logic       clk;
    logic       rst_n;
    addr_t      bus_addr;
    word_t      bus_wdata;
    access_n_t  write_n;
    access_n_t  read_n;
    logic       read_complete;
    byte_t      ui_in;
    word_t      rdata;
    logic       data_ready;
    byte_t      uo_out;
    logic       audio;
    logic       audio_select;
    offset_t    slot_offset;
    word_t      slot_wdata;
    access_n_t [`PB_USER_SLOTS-1:0]              user_write_n;
    access_n_t [`PB_USER_SLOTS-1:0]              user_read_n;
    word_t     [`PB_USER_SLOTS-1:`PB_EXT_FIRST]  user_rdata;
    logic      [`PB_USER_SLOTS-1:`PB_EXT_FIRST]  user_ready;
    byte_t     [`PB_USER_SLOTS-1:`PB_EXT_FIRST]  user_pins;
    logic      [`PB_SIMPLE_SLOTS-1:0]            simple_write;
    byte_t     [`PB_SIMPLE_SLOTS-1:0]            simple_rdata;
    byte_t     [`PB_SIMPLE_SLOTS-1:0]            simple_pins;

    // slot model state
    integer     seed = 32'h3e0d;
    byte_t      data_flip;
    logic [1:0] ready_delay [`PB_USER_SLOTS];
    logic [1:0] wait_cnt [`PB_USER_SLOTS];
    logic [`PB_USER_SLOTS-1:0] was_reading;
    int         read_starts [`PB_USER_SLOTS];

    logic [31:0] stim [MAX_LINES*FIELDS];
    int          n_lines;
    int          cycle_count;
    int          cycle_limit;

    periph_bus_top i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (bus_addr),
        .i_wdata         (bus_wdata),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .o_rdata         (rdata),
        .o_data_ready    (data_ready),
        .i_ui_in         (ui_in),
        .o_uo_out        (uo_out),
        .o_audio         (audio),
        .o_audio_select  (audio_select),
        .o_slot_offset   (slot_offset),
        .o_slot_wdata    (slot_wdata),
        .o_user_write_n  (user_write_n),
        .o_user_read_n   (user_read_n),
        .i_user_rdata    (user_rdata),
        .i_user_ready    (user_ready),
        .i_user_pins     (user_pins),
        .o_simple_write  (simple_write),
        .i_simple_rdata  (simple_rdata),
        .i_simple_pins   (simple_pins)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // user slot k answers with the byte 0xk0 repeated, its pins are 0xk0 plus k
    for (genvar k = `PB_EXT_FIRST; k < `PB_USER_SLOTS; k++) begin : g_user_slot
        assign user_rdata[k] = {4{8'(k * 16) ^ data_flip}};
        assign user_pins[k]  = 8'(k * 17);
        assign user_ready[k] = (user_read_n[k] != NONE) && (wait_cnt[k] >= ready_delay[k]);
    end

    for (genvar j = 0; j < `PB_SIMPLE_SLOTS; j++) begin : g_simple_slot
        assign simple_rdata[j] = 8'(8'hA0 + j);
        assign simple_pins[j]  = 8'(8'h50 + j);
    end

    // counts read strobes per slot and times each slot's ready
    always @(posedge clk) begin : slot_model
        logic [31:0] rnd;
        logic        reading;
        for (int k = 0; k < `PB_USER_SLOTS; k++) begin
            reading = user_read_n[k] != NONE;
            if (reading && !was_reading[k]) begin
                read_starts[k] = read_starts[k] + 1;
            end
            if (!reading) begin
                // latency of the next read, 0 to 3 cycles
                rnd = $random(seed);
                ready_delay[k] <= rnd[1:0];
                wait_cnt[k]    <= 2'd0;
            end else if (wait_cnt[k] != 2'd3) begin
                wait_cnt[k] <= wait_cnt[k] + 2'd1;
            end
            was_reading[k] <= reading;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("Fail: %s = 0x%h, expected 0x%h", name, got, expected);
        abort_run();
    endtask

    // the addressed user slot sees the word strobe, all others stay idle
    function automatic logic [2*`PB_USER_SLOTS-1:0] user_write_strobes(input addr_t a);
        logic [2*`PB_USER_SLOTS-1:0] strobes;
        strobes = '1;
        if (!a[9]) begin
            strobes[a[8:6]*2 +: 2] = WORD;
        end
        return strobes;
    endfunction

    function automatic logic [`PB_SIMPLE_SLOTS-1:0] simple_write_strobes(input addr_t a);
        logic [`PB_SIMPLE_SLOTS-1:0] sel;
        sel = '0;
        if (a[9]) begin
            sel[a[5:4]] = 1'b1;
        end
        return sel;
    endfunction

    task automatic write_slot(input addr_t a, input word_t data, input byte_t ui);
        logic [2*`PB_USER_SLOTS-1:0] want_user;
        logic [`PB_SIMPLE_SLOTS-1:0] want_simple;
        want_user   = user_write_strobes(a);
        want_simple = simple_write_strobes(a);
        @(negedge clk);
        bus_addr  = a;
        bus_wdata = data;
        write_n   = WORD;
        ui_in     = ui;
        // strobes and write ack are combinational
        #(CLK_PERIOD / 4);
        assert (data_ready === 1'b1)
            else report_mismatch("o_data_ready", 32'(data_ready), 32'h1);
        assert (user_write_n === want_user)
            else report_mismatch("o_user_write_n", 32'(user_write_n), 32'(want_user));
        assert (simple_write === want_simple)
            else report_mismatch("o_simple_write", 32'(simple_write), 32'(want_simple));
        // every slot sees the low address bits and the write data
        assert (slot_offset === a[5:0])
            else report_mismatch("o_slot_offset", 32'(slot_offset), 32'(a[5:0]));
        assert (slot_wdata === data)
            else report_mismatch("o_slot_wdata", slot_wdata, data);
        @(negedge clk);
        write_n = NONE;
    endtask

    task automatic read_slot(input addr_t a, input byte_t ui, input word_t expected,
                             input bit late_complete);
        int starts_before [`PB_USER_SLOTS];
        int want_starts;
        @(negedge clk);
        starts_before = read_starts;
        bus_addr = a;
        read_n   = WORD;
        ui_in    = ui;
        @(negedge clk);
        while (data_ready !== 1'b1) begin
            @(negedge clk);
        end
        assert (rdata === expected)
            else report_mismatch("o_rdata", rdata, expected);
        // no slot sees the read while the result goes out
        assert (user_read_n === {2*`PB_USER_SLOTS{1'b1}})
            else report_mismatch("o_user_read_n", 32'(user_read_n),
                                 32'({2*`PB_USER_SLOTS{1'b1}}));
        if (late_complete) begin
            // slot data changes while the core still holds the read
            data_flip = 8'hFF;
            repeat (3) begin
                @(negedge clk);
                assert (rdata === expected)
                    else report_mismatch("o_rdata", rdata, expected);
                assert (data_ready === 1'b0)
                    else report_mismatch("o_data_ready", 32'(data_ready), 32'h0);
            end
        end
        read_n        = NONE;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
        data_flip     = 8'h00;
        if (!late_complete) begin
            for (int k = 0; k < `PB_USER_SLOTS; k++) begin
                want_starts = starts_before[k];
                if (!a[9] && a[8:6] == k) begin
                    want_starts = want_starts + 1;
                end
                assert (read_starts[k] == want_starts)
                    else report_mismatch("o_user_read_n strobe count", read_starts[k],
                                         want_starts);
            end
        end
    endtask

    // expected holds {audio select, audio, pins} in bits 9..0
    task automatic check_pins(input byte_t ui, input word_t expected);
        @(negedge clk);
        ui_in = ui;
        @(negedge clk);
        assert (uo_out === expected[7:0])
            else report_mismatch("o_uo_out", 32'(uo_out), 32'(expected[7:0]));
        assert (audio === expected[8])
            else report_mismatch("o_audio", 32'(audio), 32'(expected[8]));
        assert (audio_select === expected[9])
            else report_mismatch("o_audio_select", 32'(audio_select), 32'(expected[9]));
    endtask

    initial begin
        logic [31:0] op;
        clk           = 1'b0;
        rst_n         = 1'b0;
        bus_addr      = '0;
        bus_wdata     = '0;
        write_n       = NONE;
        read_n        = NONE;
        read_complete = 1'b0;
        ui_in         = '0;
        data_flip     = '0;
        was_reading   = '0;
        cycle_count   = 0;
        foreach (stim[i]) begin
            stim[i] = '1;
        end
        $readmemh("periph_bus_stimulus.txt", stim);
        n_lines = 0;
        while (n_lines < MAX_LINES && stim[n_lines*FIELDS] !== '1) begin
            n_lines++;
        end
        // slowest line is a held read of about ten cycles
        cycle_limit = n_lines * 10 + 50;
        if (n_lines == 0) begin
            $display("No operations could be read from the stimulus file");
            abort_run();
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < n_lines; i++) begin
            op = stim[i*FIELDS];
            case (op)
                32'h0: write_slot(stim[i*FIELDS+1][9:0], stim[i*FIELDS+2],
                                  stim[i*FIELDS+3][7:0]);
                32'h1: read_slot(stim[i*FIELDS+1][9:0], stim[i*FIELDS+3][7:0],
                                 stim[i*FIELDS+4], 1'b0);
                32'h2: check_pins(stim[i*FIELDS+3][7:0], stim[i*FIELDS+4]);
                32'h3: read_slot(stim[i*FIELDS+1][9:0], stim[i*FIELDS+3][7:0],
                                 stim[i*FIELDS+4], 1'b1);
                default: begin
                    $display("Unknown operation %0h on stimulus line %0d", op, i + 1);
                    abort_run();
                end
            endcase
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== periph_bus_stimulus.txt ====
// columns: op addr data ui_in expected, all hex
// op 0 write, 1 read, 2 pin check {audio_select, audio, uo_out}, 3 read held across a data change
2 000 00000000 00 00000002
0 040 000000F0 00 00000000
2 000 00000000 00 000000F2
1 040 00000000 00 000000F0
1 044 00000000 A5 000000A5
0 060 00000003 00 00000000
0 07C 00000009 00 00000000
0 070 00000004 00 00000000
2 000 00000000 3C 00000063
1 07C 00000000 00 00000009
1 060 00000000 00 00000003
1 048 00000000 00 00000000
1 080 00000000 00 20202020
1 0C4 00000000 00 30303030
1 108 00000000 00 40404040
1 140 00000000 00 50505050
1 184 00000000 00 60606060
1 1C0 00000000 00 70707070
1 200 00000000 00 000000A0
1 210 00000000 00 000000A1
1 220 00000000 00 000000A2
1 230 00000000 00 000000A3
3 0C0 00000000 00 30303030
0 210 00000012 00 00000000
0 0C0 12345678 00 00000000
0 050 0000000E 00 00000000
2 000 00000000 00 00000363
1 050 00000000 00 0000000E
0 050 00000000 00 00000000
2 000 00000000 00 00000063

// ==== filelist.f ====
+incdir+.
periph_bus_pkg.sv
periph_slot_select.sv
periph_read_hold.sv
periph_gpio_regs.sv
periph_pin_mux.sv
periph_bus_top.sv
tb_periph_bus.sv

// ==== Makefile ====
# Verilator build and run of the peripheral bus wrapper testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_bus
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := periph_bus_config.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) periph_bus_stimulus.txt
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
